/* logic/ntt_pkg.sv */
// ntt engine constants
// 16-point cyclic transform over the prime 97, primitive root 8
`default_nettype none

package ntt_pkg;

    // ring and field
    localparam int RING_SIZE  = 16;
    localparam int RING_DEPTH = 4;      // log2 of ring size, also the stage count
    localparam int MODULUS    = 97;
    localparam int ROOT       = 8;      // 8^8 = 96 = -1 mod 97

    // widths
    localparam int COEF_W    = 7;       // holds 0..96
    localparam int ADDR_W    = 4;
    localparam int STAGE_W   = 2;
    localparam int TW_ADDR_W = 3;       // table covers half the ring

    // pipeline timing in cycles
    localparam int BF_DELAY = 3;
    localparam int RD_DELAY = 1;
    localparam int WB_DELAY = RD_DELAY + BF_DELAY;   // read issue to write back

    // one stage issues half the ring then drains the pipe
    localparam int STAGE_CYCLES = RING_SIZE / 2 + WB_DELAY;
    localparam int NTT_CYCLES   = RING_DEPTH * STAGE_CYCLES;
    localparam int XFER_CYCLES  = RING_SIZE / 2;     // two coefficients per cycle

    // controller state encoding
    localparam int STATE_W = 2;

    localparam logic [STATE_W-1:0] ST_IDLE = 2'd0;
    localparam logic [STATE_W-1:0] ST_LOAD = 2'd1;   // bank written from data_in
    localparam logic [STATE_W-1:0] ST_NTT  = 2'd2;   // in-place butterflies
    localparam logic [STATE_W-1:0] ST_READ = 2'd3;   // pairs streamed out

endpackage

`default_nettype wire

/* logic/twiddle_rom.sv */
// twiddle rom
// powers of the root mod 97, one registered read per cycle
`timescale 1ns/1ns
`default_nettype none

module twiddle_rom
    import ntt_pkg::*;
(
    input  logic                 clk,
    input  logic [TW_ADDR_W-1:0] tw_addr,
    output logic [COEF_W-1:0]    twiddle
);

    logic [COEF_W-1:0] tw_table [RING_SIZE/2];

    // root^e mod q, evaluated at elaboration
    function automatic int pow_root(input int e);
        int acc;
        acc = 1;
        for (int k = 0; k < e; k++) begin
            acc = (acc * ROOT) % MODULUS;
        end
        return acc;
    endfunction

    for (genvar e = 0; e < RING_SIZE/2; e++) begin : g_table
        assign tw_table[e] = COEF_W'(pow_root(e));
    end

    // output register lines up with the bank read
    always_ff @(posedge clk) begin
        twiddle <= tw_table[tw_addr];
    end

endmodule

`default_nettype wire

/* logic/ntt_butterfly.sv */
// dif butterfly
// upper = a + b, lower = (a - b) * w, all mod 97
// three register stages, a new pair accepted every cycle
`timescale 1ns/1ns
`default_nettype none

module ntt_butterfly
    import ntt_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [COEF_W-1:0] coef_a,
    input  logic [COEF_W-1:0] coef_b,
    input  logic [COEF_W-1:0] twiddle,
    output logic [COEF_W-1:0] sum_out,
    output logic [COEF_W-1:0] diff_out
);

    logic [COEF_W:0]     raw_sum;   // one carry bit
    logic [COEF_W-1:0]   mod_sum;
    logic [COEF_W-1:0]   mod_diff;
    logic [COEF_W-1:0]   sum_s1;
    logic [COEF_W-1:0]   diff_s1;
    logic [COEF_W-1:0]   tw_s1;
    logic [COEF_W-1:0]   sum_s2;
    logic [2*COEF_W-1:0] prod_s2;   // full product before reduction

    // add and subtract with one conditional correction each
    assign raw_sum  = coef_a + coef_b;
    assign mod_sum  = (raw_sum >= MODULUS) ? COEF_W'(raw_sum - MODULUS) : COEF_W'(raw_sum);
    assign mod_diff = (coef_a >= coef_b) ? COEF_W'(coef_a - coef_b)
                                         : COEF_W'(coef_a + MODULUS - coef_b);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum_s1   <= '0;
            diff_s1  <= '0;
            tw_s1    <= '0;
            sum_s2   <= '0;
            prod_s2  <= '0;
            sum_out  <= '0;
            diff_out <= '0;
        end else begin
            // stage 1
            sum_s1  <= mod_sum;
            diff_s1 <= mod_diff;
            tw_s1   <= twiddle;
            // stage 2, plain multiply
            prod_s2 <= diff_s1 * tw_s1;
            sum_s2  <= sum_s1;          // sum rides alongside
            // stage 3, reduce by constant modulus
            diff_out <= COEF_W'(prod_s2 % MODULUS);
            sum_out  <= sum_s2;
        end
    end

endmodule

`default_nettype wire

/* logic/coef_bank.sv */
// coefficient bank
// ring-sized memory, two registered reads and two writes per cycle
`timescale 1ns/1ns
`default_nettype none

module coef_bank
    import ntt_pkg::*;
(
    input  logic              clk,
    input  logic [ADDR_W-1:0] rd_addr0,
    input  logic [ADDR_W-1:0] rd_addr1,
    output logic [COEF_W-1:0] rd_data0,
    output logic [COEF_W-1:0] rd_data1,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr0,
    input  logic [ADDR_W-1:0] wr_addr1,
    input  logic [COEF_W-1:0] wr_data0,
    input  logic [COEF_W-1:0] wr_data1
);

    logic [COEF_W-1:0] mem [RING_SIZE];

    // both write ports share one enable
    // addresses always differ, pair members or even/odd on load
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr0] <= wr_data0;
            mem[wr_addr1] <= wr_data1;
        end
    end

    // read latency of one cycle
    // a read at a write edge returns the old word
    always_ff @(posedge clk) begin
        rd_data0 <= mem[rd_addr0];
        rd_data1 <= mem[rd_addr1];
    end

endmodule

`default_nettype wire

/* logic/ntt_addr_gen.sv */
// ntt address generator
// walks stages and butterfly pairs, twiddle index per pair
// write-back addresses follow the reads through a delay line
`timescale 1ns/1ns
`default_nettype none

module ntt_addr_gen
    import ntt_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ntt_go,
    output logic [ADDR_W-1:0]    rd_addr0,
    output logic [ADDR_W-1:0]    rd_addr1,
    output logic [TW_ADDR_W-1:0] tw_addr,
    output logic                 wb_en,
    output logic [ADDR_W-1:0]    wb_addr0,
    output logic [ADDR_W-1:0]    wb_addr1,
    output logic                 ntt_finished
);

    logic                            busy;
    logic [STAGE_W-1:0]              stage;
    logic [$clog2(STAGE_CYCLES)-1:0] cycle_cnt;   // issue 0..7 then drain
    logic                            issue;
    logic [ADDR_W-1:0]               idx;
    logic [ADDR_W-1:0]               half;        // pair distance in this stage
    logic [ADDR_W-1:0]               offset;      // j within the group
    logic [WB_DELAY-1:0]             vld_d;
    logic [ADDR_W-1:0]               addr0_d [WB_DELAY];
    logic [ADDR_W-1:0]               addr1_d [WB_DELAY];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy      <= 1'b0;
            stage     <= '0;
            cycle_cnt <= '0;
        end else if (ntt_go) begin
            busy      <= 1'b1;
            stage     <= '0;
            cycle_cnt <= '0;
        end else if (busy) begin
            if (cycle_cnt == STAGE_CYCLES - 1) begin
                cycle_cnt <= '0;
                stage     <= stage + 1'b1;     // wraps to 0 after the last stage
                if (stage == RING_DEPTH - 1)
                    busy <= 1'b0;
            end else begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
        end
    end

    assign issue        = busy && (cycle_cnt < RING_SIZE / 2);
    assign ntt_finished = busy && (stage == RING_DEPTH - 1) && (cycle_cnt == STAGE_CYCLES - 1);

    // group*2*half + j, and its partner half above
    assign idx      = ADDR_W'(cycle_cnt);
    assign half     = ADDR_W'(RING_SIZE / 2) >> stage;
    assign offset   = idx & (half - 1'b1);
    assign rd_addr0 = ((idx - offset) << 1) + offset;
    assign rd_addr1 = rd_addr0 + half;
    assign tw_addr  = TW_ADDR_W'(offset << stage);   // root of the sub-transform is 8^(2^s)

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            vld_d <= '0;
        else
            vld_d <= {vld_d[WB_DELAY-2:0], issue};
    end

    always_ff @(posedge clk) begin
        addr0_d[0] <= rd_addr0;
        addr1_d[0] <= rd_addr1;
        for (int k = 1; k < WB_DELAY; k++) begin
            addr0_d[k] <= addr0_d[k-1];
            addr1_d[k] <= addr1_d[k-1];
        end
    end

    assign wb_en    = vld_d[WB_DELAY-1];   // lands with butterfly output
    assign wb_addr0 = addr0_d[WB_DELAY-1];
    assign wb_addr1 = addr1_d[WB_DELAY-1];

endmodule

`default_nettype wire

/* logic/ntt_ctrl.sv */
// ntt controller
// idle, load, transform and readout states on one counter
// steers the bank ports and drives done and data_out
`timescale 1ns/1ns
`default_nettype none

module ntt_ctrl
    import ntt_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                load,
    input  logic                start,
    input  logic [2*COEF_W-1:0] data_in,
    input  logic                ntt_finished,
    input  logic [COEF_W-1:0]   bf_sum,
    input  logic [COEF_W-1:0]   bf_diff,
    input  logic [ADDR_W-1:0]   ag_rd_addr0,
    input  logic [ADDR_W-1:0]   ag_rd_addr1,
    input  logic [ADDR_W-1:0]   ag_wb_addr0,
    input  logic [ADDR_W-1:0]   ag_wb_addr1,
    input  logic                ag_wb_en,
    input  logic [COEF_W-1:0]   bank_data0,
    input  logic [COEF_W-1:0]   bank_data1,
    output logic                ntt_go,
    output logic [ADDR_W-1:0]   bank_rd_addr0,
    output logic [ADDR_W-1:0]   bank_rd_addr1,
    output logic [ADDR_W-1:0]   bank_wr_addr0,
    output logic [ADDR_W-1:0]   bank_wr_addr1,
    output logic                bank_wr_en,
    output logic [COEF_W-1:0]   bank_wr_data0,
    output logic [COEF_W-1:0]   bank_wr_data1,
    output logic                done,
    output logic [2*COEF_W-1:0] data_out
);

    logic [STATE_W-1:0]               state;
    logic [$clog2(XFER_CYCLES+2)-1:0] sys_cntr;   // up to 9 in readout
    logic [$clog2(XFER_CYCLES+2)-1:0] cntr_m1;
    logic [ADDR_W-2:0]                ld_pair;
    logic [ADDR_W-2:0]                rd_pair;

    assign ntt_go  = (state == ST_IDLE) && start && !load;   // load has priority
    assign cntr_m1 = sys_cntr - 1'b1;
    assign ld_pair = sys_cntr[ADDR_W-2:0];
    assign rd_pair = cntr_m1[ADDR_W-2:0];      // positions 2c-2, 2c-1

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= ST_IDLE;
            sys_cntr <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    sys_cntr <= '0;
                    if (load)
                        state <= ST_LOAD;
                    else if (start)
                        state <= ST_NTT;
                end
                ST_LOAD: begin
                    if (sys_cntr == XFER_CYCLES - 1) begin
                        state    <= ST_IDLE;
                        sys_cntr <= '0;
                    end else begin
                        sys_cntr <= sys_cntr + 1'b1;
                    end
                end
                ST_NTT: begin
                    sys_cntr <= '0;               // counter idle while addr_gen runs
                    if (ntt_finished)
                        state <= ST_READ;
                end
                default: begin                    // readout, extra cycle for bank latency
                    if (sys_cntr == XFER_CYCLES + 1) begin
                        state    <= ST_IDLE;
                        sys_cntr <= '0;
                    end else begin
                        sys_cntr <= sys_cntr + 1'b1;
                    end
                end
            endcase
        end
    end

    always_comb begin
        bank_rd_addr0 = {rd_pair, 1'b0};     // readout addressing
        bank_rd_addr1 = {rd_pair, 1'b1};
        bank_wr_en    = 1'b0;
        bank_wr_addr0 = ag_wb_addr0;
        bank_wr_addr1 = ag_wb_addr1;
        bank_wr_data0 = bf_sum;
        bank_wr_data1 = bf_diff;
        case (state)
            ST_LOAD: begin
                bank_wr_en    = 1'b1;
                bank_wr_addr0 = {ld_pair, 1'b0};
                bank_wr_addr1 = {ld_pair, 1'b1};
                bank_wr_data0 = data_in[COEF_W-1:0];          // even index low
                bank_wr_data1 = data_in[2*COEF_W-1:COEF_W];
            end
            ST_NTT: begin
                bank_rd_addr0 = ag_rd_addr0;
                bank_rd_addr1 = ag_rd_addr1;
                bank_wr_en    = ag_wb_en;
            end
            default: ;
        endcase
    end

    // done one cycle ahead of the first pair
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done     <= 1'b0;
            data_out <= '0;
        end else begin
            done <= (state == ST_READ) && (sys_cntr == 1);
            if ((state == ST_READ) && (sys_cntr >= 2))
                data_out <= {bank_data1, bank_data0};
            else
                data_out <= '0;
        end
    end

endmodule

`default_nettype wire

/* logic/ntt_top.sv */
// ntt engine top
// single butterfly, in-place 16-point transform, bit-reversed output
`timescale 1ns/1ns
`default_nettype none

module ntt_top
    import ntt_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                load,
    input  logic                start,
    input  logic [2*COEF_W-1:0] data_in,
    output logic                done,
    output logic [2*COEF_W-1:0] data_out
);

    logic                 ntt_go;
    logic                 ntt_finished;
    logic [ADDR_W-1:0]    ag_rd_addr0;
    logic [ADDR_W-1:0]    ag_rd_addr1;
    logic [ADDR_W-1:0]    ag_wb_addr0;
    logic [ADDR_W-1:0]    ag_wb_addr1;
    logic                 ag_wb_en;
    logic [TW_ADDR_W-1:0] tw_addr;
    logic [COEF_W-1:0]    twiddle;
    logic [ADDR_W-1:0]    bank_rd_addr0;
    logic [ADDR_W-1:0]    bank_rd_addr1;
    logic [ADDR_W-1:0]    bank_wr_addr0;
    logic [ADDR_W-1:0]    bank_wr_addr1;
    logic                 bank_wr_en;
    logic [COEF_W-1:0]    bank_wr_data0;
    logic [COEF_W-1:0]    bank_wr_data1;
    logic [COEF_W-1:0]    bank_data0;     // feeds butterfly and readout
    logic [COEF_W-1:0]    bank_data1;
    logic [COEF_W-1:0]    bf_sum;
    logic [COEF_W-1:0]    bf_diff;

    ntt_ctrl i_ntt_ctrl (
        .clk, .reset, .load, .start, .data_in,
        .ntt_finished, .bf_sum, .bf_diff,
        .ag_rd_addr0, .ag_rd_addr1, .ag_wb_addr0, .ag_wb_addr1, .ag_wb_en,
        .bank_data0, .bank_data1, .ntt_go,
        .bank_rd_addr0, .bank_rd_addr1, .bank_wr_addr0, .bank_wr_addr1,
        .bank_wr_en, .bank_wr_data0, .bank_wr_data1,
        .done, .data_out
    );

    ntt_addr_gen i_ntt_addr_gen (
        .clk, .reset, .ntt_go,
        .rd_addr0(ag_rd_addr0), .rd_addr1(ag_rd_addr1), .tw_addr,
        .wb_en(ag_wb_en), .wb_addr0(ag_wb_addr0), .wb_addr1(ag_wb_addr1),
        .ntt_finished
    );

    coef_bank i_coef_bank (
        .clk,
        .rd_addr0(bank_rd_addr0), .rd_addr1(bank_rd_addr1),
        .rd_data0(bank_data0), .rd_data1(bank_data1),
        .wr_en(bank_wr_en), .wr_addr0(bank_wr_addr0), .wr_addr1(bank_wr_addr1),
        .wr_data0(bank_wr_data0), .wr_data1(bank_wr_data1)
    );

    twiddle_rom i_twiddle_rom (.clk, .tw_addr, .twiddle);

    ntt_butterfly i_ntt_butterfly (
        .clk, .reset,
        .coef_a(bank_data0), .coef_b(bank_data1), .twiddle,
        .sum_out(bf_sum), .diff_out(bf_diff)
    );

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
// testbench clock source
// free running, 40 ns period
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // half period
    end

endmodule

`default_nettype wire

/* bench/ntt_tb.sv */
// ntt engine testbench
// directed tests against a naive dft mod 97 with bit-reversed placement
`timescale 1ns/1ns
`default_nettype none

module ntt_tb
    import ntt_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 6 * (NTT_CYCLES + 40) + 10;   // six runs plus reset

    logic                clk;
    logic                reset;
    logic                load;
    logic                start;
    logic [2*COEF_W-1:0] data_in;
    logic                done;
    logic [2*COEF_W-1:0] data_out;

    logic [COEF_W-1:0] stim       [RING_SIZE];   // next load contents
    logic [COEF_W-1:0] bank_model [RING_SIZE];   // what the bank should hold
    logic [COEF_W-1:0] expected   [RING_SIZE];
    logic [COEF_W-1:0] observed   [RING_SIZE];
    logic [31:0]       lfsr_state;
    int                cycle_count = 0;

    tb_clock i_tb_clock (.clk);

    ntt_top i_ntt_top (.clk, .reset, .load, .start, .data_in, .done, .data_out);

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    // run length guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES)
            fail_run("timeout: the tests did not finish in the allowed number of cycles");
    end

    task automatic check_coef(input string name, input logic [COEF_W-1:0] exp_val,
                              input logic [COEF_W-1:0] act_val);
        if (act_val !== exp_val)
            fail_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp_val, act_val));
    endtask

    task automatic check_word(input string name, input logic [2*COEF_W-1:0] exp_val,
                              input logic [2*COEF_W-1:0] act_val);
        if (act_val !== exp_val)
            fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp_val, act_val));
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val)
            fail_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp_val, act_val));
    endtask

    task automatic check_latency(input string name, input int exp_val, input int act_val);
        if (act_val != exp_val)
            fail_run($sformatf("Mismatch %s latency: expected %0d, actual %0d",
                               name, exp_val, act_val));
    endtask

    function automatic logic [ADDR_W-1:0] bit_reverse(input logic [ADDR_W-1:0] idx);
        logic [ADDR_W-1:0] r;
        for (int b = 0; b < ADDR_W; b++)
            r[b] = idx[ADDR_W-1-b];
        return r;
    endfunction

    // galois form, taps x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_coef(output logic [COEF_W-1:0] c);
        logic [COEF_W-1:0] raw;
        for (int b = 0; b < COEF_W; b++) begin
            raw[b]     = lfsr_state[0];    // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
        c = COEF_W'(raw % MODULUS);
    endtask

    // X[k] = sum a[i]*8^(i*k), placed at position bitrev(k)
    task automatic model_transform();
        int dft [RING_SIZE];
        int step;
        int wpow;
        int acc;
        for (int k = 0; k < RING_SIZE; k++) begin
            step = 1;
            for (int e = 0; e < k; e++)
                step = (step * ROOT) % MODULUS;   // 8^k
            acc  = 0;
            wpow = 1;
            for (int i = 0; i < RING_SIZE; i++) begin
                acc  = (acc + int'(bank_model[i]) * wpow) % MODULUS;
                wpow = (wpow * step) % MODULUS;
            end
            dft[k] = acc;
        end
        for (int p = 0; p < RING_SIZE; p++)
            expected[p] = COEF_W'(dft[bit_reverse(ADDR_W'(p))]);
        bank_model = expected;   // transform is in place
    endtask

    task automatic load_coefs();
        @(posedge clk);
        load <= 1'b1;
        for (int i = 0; i < XFER_CYCLES; i++) begin
            @(posedge clk);
            load    <= 1'b0;
            data_in <= {stim[2*i+1], stim[2*i]};   // even index low
        end
        @(posedge clk);
        data_in    <= '0;
        bank_model = stim;
    endtask

    // start, wait for done, collect the 8 pairs; load_at injects a stray load
    task automatic run_transform(input string name, input int load_at);
        int cycles;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);                 // start sampled here
        start  <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            load    <= (cycles == load_at);
            data_in <= (cycles == load_at) ? {(2*COEF_W){1'b1}} : '0;
            @(negedge clk);
        end while (!done);
        check_latency(name, NTT_CYCLES + 2, cycles);
        for (int i = 0; i < XFER_CYCLES; i++) begin
            @(negedge clk);
            if (i == 0)
                check_flag({name, " done pulse width"}, 1'b0, done);
            observed[2*i]   = data_out[COEF_W-1:0];
            observed[2*i+1] = data_out[2*COEF_W-1:COEF_W];
        end
        @(negedge clk);
        check_word({name, " data_out after readout"}, '0, data_out);
        for (int p = 0; p < RING_SIZE; p++)
            check_coef($sformatf("%s pos %0d", name, p), expected[p], observed[p]);
    endtask

    task automatic test_idle_after_reset();
        repeat (20) begin
            @(negedge clk);
            check_flag("idle done", 1'b0, done);
            check_word("idle data_out", '0, data_out);
        end
    endtask

    task automatic test_impulse();
        foreach (stim[i])
            stim[i] = (i == 0) ? COEF_W'(1) : '0;
        load_coefs();
        foreach (expected[p])
            expected[p] = COEF_W'(1);   // flat spectrum
        bank_model = expected;
        run_transform("impulse", 0);
    endtask

    task automatic test_constant(input logic [COEF_W-1:0] c);
        foreach (stim[i])
            stim[i] = c;
        load_coefs();
        foreach (expected[p])
            expected[p] = (p == 0) ? COEF_W'((RING_SIZE * c) % MODULUS) : '0;   // dc only
        bank_model = expected;
        run_transform("constant", 0);
    endtask

    task automatic test_random();
        for (int run = 0; run < 3; run++) begin
            foreach (stim[i])
                random_coef(stim[i]);
            load_coefs();
            model_transform();
            run_transform($sformatf("random %0d", run), 0);
        end
    endtask

    // second pass on the stored result, stray load mid transform
    task automatic test_in_place();
        model_transform();
        run_transform("in place", 10);
    endtask

    initial begin
        reset      = 1'b1;
        load       = 1'b0;
        start      = 1'b0;
        data_in    = '0;
        lfsr_state = 32'he3c7981f;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        test_idle_after_reset();
        test_impulse();
        test_constant(COEF_W'(45));
        test_random();
        test_in_place();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
logic/ntt_pkg.sv
logic/twiddle_rom.sv
logic/ntt_butterfly.sv
logic/coef_bank.sv
logic/ntt_addr_gen.sv
logic/ntt_ctrl.sv
logic/ntt_top.sv
bench/tb_clock.sv
bench/ntt_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ntt testbench with verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns -Wno-fatal --top-module ntt_tb \
    -f verilog.f > sim.log 2>&1 \
    && ./obj_dir/Vntt_tb >> sim.log 2>&1 \
    || echo "Test failed" >> sim.log
if grep -q "Test failed" sim.log; then echo "simulation FAILED"; exit 1; fi
echo "simulation passed"
